// ==== include/dram_ctrl_config.svh ====
`ifndef DRAM_CTRL_CONFIG_SVH
`define DRAM_CTRL_CONFIG_SVH

// address field widths
// layout from low bits up: column, bank, bank group, row
`define DC_COL_W  8
`define DC_BANK_W 2
`define DC_BG_W   2
`define DC_ROW_W  8

// field offsets, each one follows the field below it
`define DC_COL_OFS  0
`define DC_BANK_OFS (`DC_COL_OFS + `DC_COL_W)
`define DC_BG_OFS   (`DC_BANK_OFS + `DC_BANK_W)
`define DC_ROW_OFS  (`DC_BG_OFS + `DC_BG_W)

`define DC_ADDR_W 20 // col + bank + bg + row

// request queue depth
`define DC_QUEUE_DEPTH 8

// dram timing in clk cycles
`define DC_T_RCD   4  // act to rd/wr, same bank
`define DC_T_RP    4  // pre to act, same bank
`define DC_T_RAS   10 // act to pre, same bank
`define DC_T_CCD_L 4  // column to column, same bank group
`define DC_T_CCD_S 2  // column to column, other bank group
`define DC_T_RRD_L 4  // act to act, same bank group
`define DC_T_RRD_S 2  // act to act, other bank group

// refresh
`define DC_T_REFI 400 // interval between REF commands
`define DC_T_RFC  20  // bus idle after a REF

`define DC_TIMER_W 5 // saturating bank and bus timers

`endif

// ==== design/dram_ctrl_pkg.sv ====
`default_nettype none

`include "dram_ctrl_config.svh"

package dram_ctrl_pkg;

	// command bus opcodes
	typedef enum logic [2:0] {
		NOP = 3'd0, // idle bus
		ACT = 3'd1, // open a row
		PRE = 3'd2, // close the open row of one bank
		RD  = 3'd3,
		WR  = 3'd4,
		REF = 3'd5  // refresh, closes all rows
	} dram_cmd_t;

	// one request as it sits in the queue
	typedef struct packed {
		logic                  write; // 1 = write, 0 = read
		logic [`DC_ADDR_W-1:0] addr;  // {row, bg, bank, col}
	} mem_req_t;

	// bank select, bank group on top so it packs into a flat index
	typedef struct packed {
		logic [`DC_BG_W-1:0]   bg;
		logic [`DC_BANK_W-1:0] bank;
	} bank_addr_t;

	typedef logic [`DC_ROW_W-1:0] row_t;

endpackage

`default_nettype wire

// ==== design/req_fifo.sv ====
`default_nettype none

`include "dram_ctrl_config.svh"

module req_fifo #(
	parameter type payload_t = dram_ctrl_pkg::mem_req_t,
	parameter int  DEPTH     = `DC_QUEUE_DEPTH
) (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic push,      // accepted only while not full
	input  payload_t  push_data,
	input  wire logic pop,       // head was consumed
	output logic      head_valid,
	output payload_t  head_req,
	output logic      full
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t   mem [DEPTH]; // circular storage
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_push;
	logic do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && head_valid; // never pop an empty queue

	assign head_valid = (count != '0);
	assign head_req   = mem[rd_ptr];
	assign full       = (count == CNT_W'(DEPTH));

	// storage, written at the tail
	always_ff @(posedge clk) begin
		if (do_push) mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) // wrap at DEPTH, not at a power of two
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/bank_scheduler.sv ====
`default_nettype none

`include "dram_ctrl_config.svh"

module bank_scheduler (
	input  wire logic                  clk,
	input  wire logic                  rst_n,
	input  wire logic                  head_valid,
	input  dram_ctrl_pkg::mem_req_t    head_req,
	output logic                       sched_req,  // next command is legal now
	output dram_ctrl_pkg::dram_cmd_t   sched_cmd,
	output logic [`DC_ADDR_W-1:0]      sched_addr,
	input  wire logic                  sched_grant,
	input  wire logic                  ref_grant,
	output logic                       pop         // head request is done
);

	localparam int IDX_W     = `DC_BG_W + `DC_BANK_W;
	localparam int NUM_BANKS = 1 << IDX_W;
	localparam int TW        = `DC_TIMER_W;

	// per bank state
	logic                    open_flag [NUM_BANKS];
	dram_ctrl_pkg::row_t     open_row  [NUM_BANKS];
	logic [TW-1:0]           rcd_cnt   [NUM_BANKS]; // act to column, counts down
	logic [TW-1:0]           rp_cnt    [NUM_BANKS]; // pre to act
	logic [TW-1:0]           ras_cnt   [NUM_BANKS]; // act to pre

	// bus wide history for ccd / rrd
	logic [`DC_BG_W-1:0] last_col_bg;
	logic [`DC_BG_W-1:0] last_act_bg;
	logic [TW-1:0]       col_since; // cycles since last column grant, saturates
	logic [TW-1:0]       act_since; // cycles since last act grant, saturates

	// head request decode
	dram_ctrl_pkg::bank_addr_t head_ba;
	dram_ctrl_pkg::row_t       head_row;
	logic [IDX_W-1:0]          head_idx;
	logic row_hit;
	logic ccd_ok;
	logic rrd_ok;
	logic cmd_ok;

	assign head_ba.bg   = head_req.addr[`DC_BG_OFS +: `DC_BG_W];
	assign head_ba.bank = head_req.addr[`DC_BANK_OFS +: `DC_BANK_W];
	assign head_row     = head_req.addr[`DC_ROW_OFS +: `DC_ROW_W];
	assign head_idx     = head_ba; // {bg, bank} flattened

	assign row_hit = open_flag[head_idx] && (open_row[head_idx] == head_row);

	// L value within the same bank group, S across groups
	assign ccd_ok = (last_col_bg == head_ba.bg) ? (col_since >= `DC_T_CCD_L)
	                                             : (col_since >= `DC_T_CCD_S);
	assign rrd_ok = (last_act_bg == head_ba.bg) ? (act_since >= `DC_T_RRD_L)
	                                             : (act_since >= `DC_T_RRD_S);

	// pick the next step for the head request
	always_comb begin
		sched_cmd = dram_ctrl_pkg::NOP;
		cmd_ok    = 1'b0;
		if (head_valid) begin
			if (row_hit) begin // only the column command left
				sched_cmd = head_req.write ? dram_ctrl_pkg::WR : dram_ctrl_pkg::RD;
				cmd_ok    = (rcd_cnt[head_idx] == '0) && ccd_ok;
			end else if (open_flag[head_idx]) begin // wrong row open, close it first
				sched_cmd = dram_ctrl_pkg::PRE;
				cmd_ok    = (ras_cnt[head_idx] == '0);
			end else begin // precharged bank
				sched_cmd = dram_ctrl_pkg::ACT;
				cmd_ok    = (rp_cnt[head_idx] == '0) && rrd_ok;
			end
		end
	end

	assign sched_req  = cmd_ok;
	assign sched_addr = head_req.addr; // full address on every bank command
	assign pop        = sched_grant &&
	                    (sched_cmd == dram_ctrl_pkg::RD || sched_cmd == dram_ctrl_pkg::WR);

	// control state: flags, timers, history
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_BANKS; i++) begin
				open_flag[i] <= 1'b0;
				rcd_cnt[i]   <= '0;
				rp_cnt[i]    <= '0;
				ras_cnt[i]   <= '0;
			end
			last_col_bg <= '0;
			last_act_bg <= '0;
			col_since   <= '1; // start saturated, nothing issued yet
			act_since   <= '1;
		end else begin
			// free running timers
			for (int i = 0; i < NUM_BANKS; i++) begin
				if (rcd_cnt[i] != '0) rcd_cnt[i] <= rcd_cnt[i] - 1'b1;
				if (rp_cnt[i] != '0)  rp_cnt[i]  <= rp_cnt[i] - 1'b1;
				if (ras_cnt[i] != '0) ras_cnt[i] <= ras_cnt[i] - 1'b1;
				if (ref_grant) open_flag[i] <= 1'b0; // REF closes every row
			end
			if (col_since != '1) col_since <= col_since + 1'b1;
			if (act_since != '1) act_since <= act_since + 1'b1;

			// loads override the countdown above
			// timers hold t-1 so a zero means the gap is met next cycle
			if (sched_grant) begin
				case (sched_cmd)
					dram_ctrl_pkg::ACT: begin
						open_flag[head_idx] <= 1'b1;
						rcd_cnt[head_idx]   <= TW'(`DC_T_RCD - 1);
						ras_cnt[head_idx]   <= TW'(`DC_T_RAS - 1);
						act_since           <= TW'(1);
						last_act_bg         <= head_ba.bg;
					end
					dram_ctrl_pkg::PRE: begin
						open_flag[head_idx] <= 1'b0;
						rp_cnt[head_idx]    <= TW'(`DC_T_RP - 1);
					end
					dram_ctrl_pkg::RD, dram_ctrl_pkg::WR: begin
						col_since   <= TW'(1);
						last_col_bg <= head_ba.bg;
					end
					default: ; // NOP never granted
				endcase
			end
		end
	end

	// open row per bank, only meaningful while open_flag is set
	always_ff @(posedge clk) begin
		if (sched_grant && sched_cmd == dram_ctrl_pkg::ACT)
			open_row[head_idx] <= head_row;
	end

endmodule

`default_nettype wire

// ==== design/refresh_timer.sv ====
`default_nettype none

`include "dram_ctrl_config.svh"

module refresh_timer (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic ref_grant, // REF taken onto the bus this cycle
	output logic      ref_req,
	output logic      ref_block  // bus held idle after a REF
);

	localparam int REFI_W = $clog2(`DC_T_REFI + 1);
	localparam int RFC_W  = $clog2(`DC_T_RFC + 1);

	logic [REFI_W-1:0] refi_cnt; // cycles until the next refresh is due
	logic [RFC_W-1:0]  rfc_cnt;  // remaining hold-off cycles

	assign ref_req   = (refi_cnt == '0);
	assign ref_block = (rfc_cnt != '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			refi_cnt <= REFI_W'(`DC_T_REFI); // first REF due T_REFI after reset
			rfc_cnt  <= '0;
		end else begin
			// reload on grant keeps REF spacing at exactly T_REFI
			// the grant edge already counts as the first cycle of the next interval
			if (ref_grant)
				refi_cnt <= REFI_W'(`DC_T_REFI - 1);
			else if (refi_cnt != '0)
				refi_cnt <= refi_cnt - 1'b1; // holds at zero until granted

			// block starts the cycle the REF shows on the bus
			if (ref_grant)
				rfc_cnt <= RFC_W'(`DC_T_RFC);
			else if (rfc_cnt != '0)
				rfc_cnt <= rfc_cnt - 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== design/cmd_arbiter.sv ====
`default_nettype none

`include "dram_ctrl_config.svh"

module cmd_arbiter (
	input  wire logic                  clk,
	input  wire logic                  rst_n,
	input  wire logic                  ref_req,
	input  wire logic                  ref_block,
	input  wire logic                  sched_req,
	input  dram_ctrl_pkg::dram_cmd_t   sched_cmd,
	input  wire logic [`DC_ADDR_W-1:0] sched_addr,
	output logic                       ref_grant,
	output logic                       sched_grant,
	output logic                       cmd_valid,  // one cycle per command
	output dram_ctrl_pkg::dram_cmd_t   cmd,
	output logic [`DC_ADDR_W-1:0]      cmd_addr
);

	// fixed priority, refresh first, nothing during the tRFC hold-off
	assign ref_grant   = ref_req && !ref_block;
	assign sched_grant = sched_req && !ref_req && !ref_block;

	// command bus, one cycle behind the grant
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cmd_valid <= 1'b0;
			cmd       <= dram_ctrl_pkg::NOP;
		end else begin
			cmd_valid <= ref_grant || sched_grant;
			if (ref_grant)
				cmd <= dram_ctrl_pkg::REF;
			else if (sched_grant)
				cmd <= sched_cmd;
			else
				cmd <= dram_ctrl_pkg::NOP; // idle bus reads as NOP
		end
	end

	// address rides along with the command
	always_ff @(posedge clk) begin
		if (ref_grant)
			cmd_addr <= '0; // REF is all-bank, no address
		else if (sched_grant)
			cmd_addr <= sched_addr;
	end

endmodule

`default_nettype wire

// ==== design/dram_ctrl_top.sv ====
`default_nettype none

`include "dram_ctrl_config.svh"

module dram_ctrl_top (
	input  wire logic                  clk,
	input  wire logic                  rst_n,
	input  wire logic                  req_valid,  // strobe, dropped while queue_full
	input  wire logic                  req_write,
	input  wire logic [`DC_ADDR_W-1:0] req_addr,
	output logic                       queue_full,
	output logic                       cmd_valid,
	output dram_ctrl_pkg::dram_cmd_t   cmd,
	output logic [`DC_ADDR_W-1:0]      cmd_addr
);

	dram_ctrl_pkg::mem_req_t  in_req;
	dram_ctrl_pkg::mem_req_t  head_req;
	dram_ctrl_pkg::dram_cmd_t sched_cmd;
	logic [`DC_ADDR_W-1:0]    sched_addr;
	logic head_valid;
	logic pop;
	logic sched_req;
	logic sched_grant;
	logic ref_req;
	logic ref_block;
	logic ref_grant;

	assign in_req.write = req_write;
	assign in_req.addr  = req_addr;

	// in-order request queue
	req_fifo #(
		.payload_t (dram_ctrl_pkg::mem_req_t),
		.DEPTH     (`DC_QUEUE_DEPTH)
	) u_req_fifo (
		.clk        (clk),
		.rst_n      (rst_n),
		.push       (req_valid),
		.push_data  (in_req),
		.pop        (pop),
		.head_valid (head_valid),
		.head_req   (head_req),
		.full       (queue_full)
	);

	bank_scheduler u_bank_scheduler (
		.clk         (clk),
		.rst_n       (rst_n),
		.head_valid  (head_valid),
		.head_req    (head_req),
		.sched_req   (sched_req),
		.sched_cmd   (sched_cmd),
		.sched_addr  (sched_addr),
		.sched_grant (sched_grant),
		.ref_grant   (ref_grant),
		.pop         (pop)
	);

	refresh_timer u_refresh_timer (
		.clk       (clk),
		.rst_n     (rst_n),
		.ref_grant (ref_grant),
		.ref_req   (ref_req),
		.ref_block (ref_block)
	);

	// scheduler and refresh share the one command bus
	cmd_arbiter u_cmd_arbiter (
		.clk         (clk),
		.rst_n       (rst_n),
		.ref_req     (ref_req),
		.ref_block   (ref_block),
		.sched_req   (sched_req),
		.sched_cmd   (sched_cmd),
		.sched_addr  (sched_addr),
		.ref_grant   (ref_grant),
		.sched_grant (sched_grant),
		.cmd_valid   (cmd_valid),
		.cmd         (cmd),
		.cmd_addr    (cmd_addr)
	);

endmodule

`default_nettype wire

// ==== tests/tb_dram_ctrl.sv ====
`default_nettype none

`include "dram_ctrl_config.svh"

module tb_dram_ctrl;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_REQ = 300;
	localparam int MAX_CYC = 12000; // 300 requests at ~35 cycles worst case, plus refresh
	localparam int IDX_W   = `DC_BG_W + `DC_BANK_W;

	logic clk;
	logic rst_n;
	logic req_valid = 1'b0;
	logic req_write = 1'b0;
	logic [`DC_ADDR_W-1:0] req_addr = '0;
	logic queue_full;
	logic cmd_valid;
	dram_ctrl_pkg::dram_cmd_t cmd;
	logic [`DC_ADDR_W-1:0] cmd_addr;

	// model state
	dram_ctrl_pkg::mem_req_t exp_q [$]; // accepted and not yet served, oldest first
	logic                bank_open [1 << IDX_W];
	dram_ctrl_pkg::row_t bank_row  [1 << IDX_W];
	int                  last_act  [1 << IDX_W]; // cycle stamps per bank
	int                  last_pre  [1 << IDX_W];
	int last_col_cyc;
	int last_act_cyc;
	logic [`DC_BG_W-1:0] last_col_bg;
	logic [`DC_BG_W-1:0] last_act_bg;
	int last_ref_cyc; // -1 until the first REF
	int next_ref_cyc; // cycle the next REF is due on the bus
	int cyc;
	int errors;
	int sent;      // requests generated by the driver
	int accepted;
	int completed;
	int refused;   // offers seen while queue_full was high
	logic will_accept; // upcoming edge takes the offered request
	logic out_of_reset;
	logic drained;

	dram_ctrl_top dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_valid  (req_valid),
		.req_write  (req_write),
		.req_addr   (req_addr),
		.queue_full (queue_full),
		.cmd_valid  (cmd_valid),
		.cmd        (cmd),
		.cmd_addr   (cmd_addr)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// address decode, layout is col, bank, bg, row from the bottom
	function automatic logic [IDX_W-1:0] bank_of(logic [`DC_ADDR_W-1:0] a);
		return a[`DC_BANK_OFS +: IDX_W]; // {bg, bank}
	endfunction

	function automatic logic [`DC_BG_W-1:0] group_of(logic [`DC_ADDR_W-1:0] a);
		return a[`DC_BG_OFS +: `DC_BG_W];
	endfunction

	function automatic dram_ctrl_pkg::row_t row_of(logic [`DC_ADDR_W-1:0] a);
		return a[`DC_ROW_OFS +: `DC_ROW_W];
	endfunction

	// only three rows in play so hits and conflicts both show up
	function automatic dram_ctrl_pkg::row_t pick_row(int unsigned k);
		case (k)
			0:       return 8'h11;
			1:       return 8'h5a;
			default: return 8'hc3;
		endcase
	endfunction

	function automatic logic [`DC_ADDR_W-1:0] make_addr();
		logic [31:0] r;
		r = $urandom;
		return {pick_row($urandom % 3), r[IDX_W-1:0], r[`DC_COL_W+IDX_W-1:IDX_W]};
	endfunction

	task automatic log_mismatch(string msg);
		errors++;
		$display("mismatch at %0t: %s", $time, msg);
	endtask

	task automatic count_failure(string msg);
		errors++;
		$display("%s", msg);
	endtask

	task automatic print_counts();
		$display("errors %0d, accepted %0d, served %0d, refused offers %0d, cycles %0d",
		         errors, accepted, completed, refused, cyc);
	endtask

	// one command seen on the bus, checked against the model
	task automatic check_cmd();
		logic [IDX_W-1:0]        b;
		logic [`DC_BG_W-1:0]     g;
		dram_ctrl_pkg::mem_req_t head;
		b = bank_of(cmd_addr);
		g = group_of(cmd_addr);
		if (last_ref_cyc >= 0 && cmd != dram_ctrl_pkg::REF && cyc - last_ref_cyc <= `DC_T_RFC)
			log_mismatch($sformatf("%s only %0d cycles after REF", cmd.name(), cyc - last_ref_cyc));
		if (cmd == dram_ctrl_pkg::REF) begin
			if (cyc != next_ref_cyc)
				log_mismatch($sformatf("REF at cycle %0d, due at %0d", cyc, next_ref_cyc));
			if (cmd_addr != '0)
				log_mismatch($sformatf("REF addr %h, expected zero", cmd_addr));
			bank_open = '{default: 1'b0}; // all rows closed
			last_ref_cyc = cyc;
			next_ref_cyc = cyc + `DC_T_REFI;
		end else if (cmd == dram_ctrl_pkg::NOP || exp_q.size() == 0) begin
			count_failure($sformatf("command %s at %0t with no request outstanding",
			                        cmd.name(), $time));
		end else begin
			head = exp_q[0];
			if (cmd_addr != head.addr)
				log_mismatch($sformatf("%s addr %h, head request %h", cmd.name(), cmd_addr,
				                       head.addr));
			case (cmd)
				dram_ctrl_pkg::ACT: begin
					if (bank_open[b])
						log_mismatch($sformatf("ACT to bank %0d with a row open", b));
					if (cyc - last_pre[b] < `DC_T_RP)
						log_mismatch($sformatf("tRP gap %0d on bank %0d", cyc - last_pre[b], b));
					if (cyc - last_act_cyc < ((g == last_act_bg) ? `DC_T_RRD_L : `DC_T_RRD_S))
						log_mismatch($sformatf("tRRD gap %0d", cyc - last_act_cyc));
					bank_open[b] = 1'b1;
					bank_row[b]  = row_of(cmd_addr);
					last_act[b]  = cyc;
					last_act_cyc = cyc;
					last_act_bg  = g;
				end
				dram_ctrl_pkg::PRE: begin
					if (!bank_open[b] || bank_row[b] == row_of(cmd_addr))
						log_mismatch($sformatf("PRE to bank %0d without a row conflict", b));
					if (cyc - last_act[b] < `DC_T_RAS)
						log_mismatch($sformatf("tRAS gap %0d on bank %0d", cyc - last_act[b], b));
					bank_open[b] = 1'b0;
					last_pre[b]  = cyc;
				end
				default: begin // RD or WR ends the request
					if (cmd != (head.write ? dram_ctrl_pkg::WR : dram_ctrl_pkg::RD))
						log_mismatch($sformatf("got %s, head request write=%0b", cmd.name(),
						                       head.write));
					if (!bank_open[b] || bank_row[b] != row_of(cmd_addr))
						log_mismatch($sformatf("%s to bank %0d off the open row", cmd.name(), b));
					if (cyc - last_act[b] < `DC_T_RCD)
						log_mismatch($sformatf("tRCD gap %0d on bank %0d", cyc - last_act[b], b));
					if (cyc - last_col_cyc < ((g == last_col_bg) ? `DC_T_CCD_L : `DC_T_CCD_S))
						log_mismatch($sformatf("tCCD gap %0d", cyc - last_col_cyc));
					last_col_cyc = cyc;
					last_col_bg  = g;
					void'(exp_q.pop_front());
					completed++;
				end
			endcase
		end
	endtask

	// requester, holds a refused request until it gets in
	always @(posedge clk) begin
		if (rst_n) begin
			if (req_valid && !will_accept) begin
				req_valid <= 1'b1;
			end else if (sent < NUM_REQ && ($urandom % 100) >= 40) begin
				req_valid <= 1'b1;
				req_write <= 1'($urandom);
				req_addr  <= make_addr();
				sent      <= sent + 1;
			end else begin
				req_valid <= 1'b0; // idle cycle
			end
		end
	end

	// monitor at the falling edge where all outputs are settled
	always @(negedge clk) begin
		cyc = cyc + 1;
		if (cyc >= MAX_CYC) begin
			count_failure($sformatf("timeout: run still busy after %0d cycles", MAX_CYC));
			print_counts();
			$display("CHECKS FAILED");
			$finish;
		end else if (!rst_n || !out_of_reset) begin
			if (cmd_valid || queue_full)
				count_failure("command bus or queue_full active during or right after reset");
			if (rst_n) // ref_req rises T_REFI after release, the bus lags the grant by one
				next_ref_cyc = cyc + `DC_T_REFI + 1;
			out_of_reset = rst_n;
		end else begin
			if (cmd_valid)
				check_cmd();
			if (cyc == next_ref_cyc) begin // a REF on time has already moved this on
				count_failure($sformatf("REF missing at cycle %0d", cyc));
				next_ref_cyc = cyc + `DC_T_REFI;
			end
			if (queue_full != (exp_q.size() == `DC_QUEUE_DEPTH))
				log_mismatch($sformatf("queue_full %0b with %0d outstanding", queue_full,
				                       exp_q.size()));
			will_accept = req_valid && !queue_full; // taken at the next rising edge
			if (will_accept) begin
				exp_q.push_back('{write: req_write, addr: req_addr});
				accepted++;
			end else if (req_valid) begin
				refused++;
			end
			drained = (sent == NUM_REQ) && !req_valid && (exp_q.size() == 0);
		end
	end

	initial begin
		void'($urandom(98113));
		errors       = 0;
		sent         = 0;
		accepted     = 0;
		completed    = 0;
		refused      = 0;
		cyc          = 0;
		will_accept  = 1'b0;
		out_of_reset = 1'b0;
		drained      = 1'b0;
		bank_open    = '{default: 1'b0};
		last_act     = '{default: -1000}; // far in the past
		last_pre     = '{default: -1000};
		last_col_cyc = -1000;
		last_act_cyc = -1000;
		last_col_bg  = '0;
		last_act_bg  = '0;
		last_ref_cyc = -1;
		next_ref_cyc = 0;
		rst_n = 1'b0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		while (!drained) @(posedge clk);
		repeat (40) @(posedge clk); // catch any stray command after the last one
		if (accepted != NUM_REQ)
			count_failure($sformatf("only %0d of %0d requests accepted", accepted, NUM_REQ));
		if (completed != accepted)
			count_failure($sformatf("%0d accepted requests never served", accepted - completed));
		print_counts();
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
design/dram_ctrl_pkg.sv
design/req_fifo.sv
design/bank_scheduler.sv
design/refresh_timer.sv
design/cmd_arbiter.sv
design/dram_ctrl_top.sv
tests/tb_dram_ctrl.sv

// ==== run.sh ====
#!/bin/sh
# build and run the DRAM scheduler testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --timescale 1ns/100ps \
	--top-module tb_dram_ctrl -f verilog.f
./obj_dir/Vtb_dram_ctrl > log.txt 2>&1
cat log.txt
if grep -q "CHECKS FAILED" log.txt; then
	echo "simulation failed, see log.txt"
	exit 1
fi
echo "simulation passed"
